/* adc_fft_pkg.sv */
`default_nettype none

package adc_fft_pkg;

  //--------------------------------------------------------------------------
  // sample and frame sizes
  //--------------------------------------------------------------------------
  localparam int sample_width = 8;     // adc word width
  localparam int frame_len    = 1024;  // samples per captured frame, also fft length
  localparam int cnt_width    = 11;    // write and read sample counters

  //--------------------------------------------------------------------------
  // sample buffer
  //--------------------------------------------------------------------------
  // depth is two frames, so a full frame plus read lag can never overflow
  localparam int fifo_depth  = 2048;
  localparam int level_width = 12;     // fill level spans 0..fifo_depth

  // readout starts two samples short of a full frame
  // the remaining writes always land before the reads catch up
  localparam logic [level_width-1:0] read_start_level = level_width'(1022);

  //--------------------------------------------------------------------------
  // capture fsm states
  //--------------------------------------------------------------------------
  localparam logic [1:0] st_idle  = 2'd0;  // waiting for a frame sync edge
  localparam logic [1:0] st_fill  = 2'd1;  // writing, level below threshold
  localparam logic [1:0] st_drain = 2'd2;  // reading out to the fft port

endpackage

`default_nettype wire

/* adc_frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_frame_buffer (
  input  logic                                 ad_clk,              // adc sample clock
  input  logic                                 sys_rst_n,           // async, active low
  input  logic                                 in_vsync,            // frame sync, active high
  input  logic [adc_fft_pkg::sample_width-1:0] ad_data_in,          // adc samples
  input  logic                                 s_axis_data_tready,  // fft ready level
  output logic                                 s_axis_data_tlast,   // last word of frame
  output logic [adc_fft_pkg::sample_width-1:0] ad_data_out,         // word to the fft
  output logic                                 ad_data_out_en       // word handed over
);

  //--------------------------------------------------------------------------
  // internal nets
  //--------------------------------------------------------------------------
  logic                                 frame_start;  // accepted or not, fsm decides
  logic [adc_fft_pkg::sample_width-1:0] wr_data;      // delayed adc samples
  logic                                 wr_en;
  logic                                 wr_done;
  logic [adc_fft_pkg::level_width-1:0]  fifo_level;

  // ad_data_out_en is the read strobe itself, s_axis_data_tlast the read end flag

  vsync_sync i_vsync_sync (
    .ad_clk      (ad_clk),
    .sys_rst_n   (sys_rst_n),
    .in_vsync    (in_vsync),
    .ad_data_in  (ad_data_in),
    .frame_start (frame_start),
    .wr_data     (wr_data)
  );

  frame_capture_fsm i_frame_capture_fsm (
    .ad_clk             (ad_clk),
    .sys_rst_n          (sys_rst_n),
    .frame_start        (frame_start),
    .wr_done            (wr_done),
    .rd_last            (s_axis_data_tlast),
    .fifo_level         (fifo_level),
    .s_axis_data_tready (s_axis_data_tready),
    .wr_en              (wr_en),
    .rd_en              (ad_data_out_en)
  );

  sample_counter i_sample_counter (
    .ad_clk    (ad_clk),
    .sys_rst_n (sys_rst_n),
    .wr_en     (wr_en),
    .rd_en     (ad_data_out_en),
    .wr_done   (wr_done),
    .rd_last   (s_axis_data_tlast)
  );

  sample_fifo i_sample_fifo (
    .ad_clk     (ad_clk),
    .sys_rst_n  (sys_rst_n),
    .wr_en      (wr_en),
    .wr_data    (wr_data),
    .rd_en      (ad_data_out_en),
    .rd_data    (ad_data_out),      // head word valid with ad_data_out_en
    .fifo_level (fifo_level)
  );

endmodule

`default_nettype wire

/* compile.f */
adc_fft_pkg.sv
vsync_sync.sv
frame_capture_fsm.sv
sample_counter.sv
sample_fifo.sv
adc_frame_buffer.sv
tb_clock_gen.sv
tb_adc_frame_buffer.sv

/* frame_capture_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_capture_fsm (
  input  logic                                ad_clk,
  input  logic                                sys_rst_n,
  input  logic                                frame_start,         // synchronized vsync rise
  input  logic                                wr_done,             // last write of the frame
  input  logic                                rd_last,             // last read of the frame
  input  logic [adc_fft_pkg::level_width-1:0] fifo_level,          // buffer fill level
  input  logic                                s_axis_data_tready,  // fft port ready level
  output logic                                wr_en,               // buffer write enable
  output logic                                rd_en                // read strobe, also out_en
);

  logic [1:0] state;
  logic       rd_active;  // readout window open, waits on ready

  //--------------------------------------------------------------------------
  // read strobe
  //--------------------------------------------------------------------------
  // one word per ready cycle while the window is open
  // buffer is fwft so the strobe doubles as the data valid
  assign rd_en = rd_active & s_axis_data_tready;

  //--------------------------------------------------------------------------
  // state and activity flags
  //--------------------------------------------------------------------------
  always_ff @(posedge ad_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state     <= adc_fft_pkg::st_idle;
      wr_en     <= 1'b0;
      rd_active <= 1'b0;
    end else begin
      // write window closes after 1024 writes, in any state
      if (wr_done) begin
        wr_en <= 1'b0;
      end

      case (state)
        adc_fft_pkg::st_idle: begin
          // only place a frame sync is honoured
          if (frame_start) begin
            wr_en <= 1'b1;
            state <= adc_fft_pkg::st_fill;
          end
        end

        adc_fft_pkg::st_fill: begin
          // frame edges here are dropped
          if (fifo_level >= adc_fft_pkg::read_start_level) begin
            rd_active <= 1'b1;                  // open readout
            state     <= adc_fft_pkg::st_drain;
          end
        end

        adc_fft_pkg::st_drain: begin
          if (rd_en && rd_last) begin
            rd_active <= 1'b0;                  // 1024th word handed over
          end
          // back to idle only once both windows are shut
          if (rd_en && rd_last && !wr_en) begin
            state <= adc_fft_pkg::st_idle;
          end
        end

        default: begin
          state <= adc_fft_pkg::st_idle;        // unused code, recover
        end
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------
  // readout window always closes together with the return to idle
  a_no_read_in_idle : assert property (
    @(posedge ad_clk) disable iff (!sys_rst_n)
    (state == adc_fft_pkg::st_idle) |-> !rd_en
  ) else $error("rd_en high while capture fsm is idle");

  // a write window only opens on an accepted frame edge
  a_wr_en_from_idle : assert property (
    @(posedge ad_clk) disable iff (!sys_rst_n)
    $rose(wr_en) |-> $past(frame_start) && ($past(state) == adc_fft_pkg::st_idle)
  ) else $error("wr_en rose without a frame_start in idle");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the frame buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module tb_adc_frame_buffer \
  -f compile.f \
  -o tb_adc_frame_buffer_sim

# a $fatal in the testbench gives a non-zero exit status
./obj_dir/tb_adc_frame_buffer_sim

/* sample_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_counter (
  input  logic ad_clk,
  input  logic sys_rst_n,
  input  logic wr_en,    // one write per high cycle
  input  logic rd_en,    // one read per high cycle
  output logic wr_done,  // current write is sample 1024
  output logic rd_last   // current read is sample 1024, drives tlast
);

  logic [adc_fft_pkg::cnt_width-1:0] wr_cnt;  // writes so far in this frame
  logic [adc_fft_pkg::cnt_width-1:0] rd_cnt;  // reads so far in this frame

  //--------------------------------------------------------------------------
  // frame end flags
  //--------------------------------------------------------------------------
  // both combinational so they line up with the event itself
  assign wr_done = wr_en && (int'(wr_cnt) == adc_fft_pkg::frame_len - 1);
  assign rd_last = rd_en && (int'(rd_cnt) == adc_fft_pkg::frame_len - 1);

  //--------------------------------------------------------------------------
  // counters
  //--------------------------------------------------------------------------
  always_ff @(posedge ad_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      wr_cnt <= '0;
    end else if (wr_done) begin
      wr_cnt <= '0;                 // ready for next frame
    end else if (wr_en) begin
      wr_cnt <= wr_cnt + 1'b1;
    end
  end

  // holds while ready is low, rd_en is already gated by it
  always_ff @(posedge ad_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      rd_cnt <= '0;
    end else if (rd_last) begin
      rd_cnt <= '0;
    end else if (rd_en) begin
      rd_cnt <= rd_cnt + 1'b1;
    end
  end

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------
  // tlast only on a real read, and the count restarts right after
  a_last_on_read : assert property (
    @(posedge ad_clk) disable iff (!sys_rst_n)
    rd_last |-> rd_en ##1 (rd_cnt == '0)
  ) else $error("rd_last without a read or read count not cleared");

  // fsm drops the write window the cycle after the last write
  a_wr_window_closes : assert property (
    @(posedge ad_clk) disable iff (!sys_rst_n)
    wr_done |=> !wr_en
  ) else $error("wr_en still high after wr_done");

endmodule

`default_nettype wire

/* sample_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_fifo (
  input  logic                                 ad_clk,
  input  logic                                 sys_rst_n,
  input  logic                                 wr_en,       // push wr_data
  input  logic [adc_fft_pkg::sample_width-1:0] wr_data,
  input  logic                                 rd_en,       // pop the head word
  output logic [adc_fft_pkg::sample_width-1:0] rd_data,     // head word, fall through
  output logic [adc_fft_pkg::level_width-1:0]  fifo_level   // words held
);

  //--------------------------------------------------------------------------
  // storage and pointers
  //--------------------------------------------------------------------------
  logic [adc_fft_pkg::sample_width-1:0] mem [adc_fft_pkg::fifo_depth];

  // pointers wrap on their own at the power of two depth
  logic [$clog2(adc_fft_pkg::fifo_depth)-1:0] wr_ptr;
  logic [$clog2(adc_fft_pkg::fifo_depth)-1:0] rd_ptr;

  logic full;   // level == depth
  logic empty;  // level == 0

  // depth is 2^(level_width-1), so the level msb alone means full
  assign full  = fifo_level[adc_fft_pkg::level_width-1];
  assign empty = (fifo_level == '0);

  //--------------------------------------------------------------------------
  // write side
  //--------------------------------------------------------------------------
  always_ff @(posedge ad_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge ad_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  //--------------------------------------------------------------------------
  // read side
  //--------------------------------------------------------------------------
  // head is read straight from the array
  // a read strobe consumes the word already on rd_data
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge ad_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= rd_ptr + 1'b1;     // next word falls through
    end
  end

  //--------------------------------------------------------------------------
  // fill level
  //--------------------------------------------------------------------------
  always_ff @(posedge ad_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      fifo_level <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   fifo_level <= fifo_level + 1'b1;  // push only
        2'b01:   fifo_level <= fifo_level - 1'b1;  // pop only
        default: fifo_level <= fifo_level;         // both or neither
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------
  // frame length and depth keep the writer from ever catching the reader
  a_no_write_full : assert property (
    @(posedge ad_clk) disable iff (!sys_rst_n)
    full |-> !wr_en
  ) else $error("write into full sample buffer");

  // read threshold keeps reads behind the writes
  a_no_read_empty : assert property (
    @(posedge ad_clk) disable iff (!sys_rst_n)
    empty |-> !rd_en
  ) else $error("read from empty sample buffer");

endmodule

`default_nettype wire

/* tb_adc_frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_adc_frame_buffer;

  localparam int frame_cycles = adc_fft_pkg::frame_len * 4;        // wait limit per frame
  localparam int watchdog_ns  = 6 * adc_fft_pkg::frame_len * 4 * 20; // six slow frames

  logic                                 ad_clk;
  logic                                 sys_rst_n;
  logic                                 in_vsync;
  logic [adc_fft_pkg::sample_width-1:0] ad_data_in = '0;  // free-running ramp
  logic                                 s_axis_data_tready;
  logic                                 s_axis_data_tlast;
  logic [adc_fft_pkg::sample_width-1:0] ad_data_out;
  logic                                 ad_data_out_en;

  // scoreboard, one entry per handed-over word
  logic [adc_fft_pkg::sample_width-1:0] words_q[$];
  logic                                 lasts_q[$];
  int                                   frames_done = 0;  // tlast words seen
  string                                cur_test = "startup";
  int                                   seed = 32'h3469_206e;

  tb_clock_gen i_tb_clock_gen (
    .ad_clk    (ad_clk),
    .sys_rst_n (sys_rst_n)
  );

  adc_frame_buffer i_adc_frame_buffer (
    .ad_clk             (ad_clk),
    .sys_rst_n          (sys_rst_n),
    .in_vsync           (in_vsync),
    .ad_data_in         (ad_data_in),
    .s_axis_data_tready (s_axis_data_tready),
    .s_axis_data_tlast  (s_axis_data_tlast),
    .ad_data_out        (ad_data_out),
    .ad_data_out_en     (ad_data_out_en)
  );

  //--------------------------------------------------------------------------
  // failure reporting and compare tasks
  //--------------------------------------------------------------------------
  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_sample(input string name,
                              input logic [adc_fft_pkg::sample_width-1:0] expected,
                              input logic [adc_fft_pkg::sample_width-1:0] actual);
    if (actual !== expected) begin
      report_failure($sformatf("[ERROR] %s: sample expected %02h, actual %02h",
                               name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("[ERROR] %s: flag expected %b, actual %b",
                               name, expected, actual));
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      report_failure($sformatf("[ERROR] %s: count expected %0d, actual %0d",
                               name, expected, actual));
    end
  endtask

  //--------------------------------------------------------------------------
  // stimulus helpers
  //--------------------------------------------------------------------------
  task automatic step();
    @(posedge ad_clk);
    #2;  // inputs move just after the edge
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) step();
  endtask

  task automatic pulse_vsync();
    in_vsync = 1'b1;
    wait_cycles(4);   // wide enough for the resync chain
    in_vsync = 1'b0;
    step();
  endtask

  // run until frames_done reaches target, optionally toggling ready at random
  task automatic wait_frames(input int target, input bit rand_ready);
    int cycles;
    int rnd;
    cycles = 0;
    while (frames_done < target) begin
      if (cycles >= frame_cycles) begin
        report_failure($sformatf("%s: frame %0d not finished within %0d cycles",
                                 cur_test, target, frame_cycles));
      end
      step();
      if (rand_ready) begin
        rnd = $random(seed);
        s_axis_data_tready = rnd[0];
      end
      cycles++;
    end
  endtask

  task automatic wait_first_output();
    int cycles;
    cycles = 0;
    while (words_q.size() == 0) begin
      if (cycles >= frame_cycles) begin
        report_failure($sformatf("%s: readout never started", cur_test));
      end
      step();
      cycles++;
    end
  endtask

  // pops one frame, ramp must be continuous and tlast only on word 1024
  task automatic check_frame(input string name);
    logic [adc_fft_pkg::sample_width-1:0] word;
    logic [adc_fft_pkg::sample_width-1:0] prev;
    logic                                 last;
    int                                   n;
    prev = '0;
    for (n = 0; n < adc_fft_pkg::frame_len; n++) begin
      if (words_q.size() == 0) begin
        report_failure($sformatf("%s: output frame ended after %0d words", name, n));
      end
      word = words_q.pop_front();
      last = lasts_q.pop_front();
      if (n > 0) begin
        check_sample(name, prev + 8'd1, word);
      end
      check_flag(name, (n == adc_fft_pkg::frame_len - 1), last);
      prev = word;
    end
  endtask

  //--------------------------------------------------------------------------
  // tests
  //--------------------------------------------------------------------------
  task automatic test_reset_idle();
    cur_test = "test_reset_idle";
    s_axis_data_tready = 1'b1;  // ready high so a stray read would show
    repeat (200) begin
      @(negedge ad_clk);
      check_flag(cur_test, 1'b0, ad_data_out_en);
      check_flag(cur_test, 1'b0, s_axis_data_tlast);
    end
    step();
    check_count(cur_test, 0, words_q.size());
  endtask

  task automatic test_single_frame();
    int base;
    cur_test = "test_single_frame";
    base = frames_done;
    s_axis_data_tready = 1'b1;
    pulse_vsync();
    wait_frames(base + 1, 1'b0);
    wait_cycles(4);             // room for a word past tlast
    check_frame(cur_test);
    check_count(cur_test, 0, words_q.size());  // exactly 1024 words
  endtask

  task automatic test_backpressure();
    int base;
    cur_test = "test_backpressure";
    base = frames_done;
    pulse_vsync();
    wait_frames(base + 1, 1'b1);   // monitor checks out_en against ready
    s_axis_data_tready = 1'b1;
    wait_cycles(4);
    check_frame(cur_test);
    check_count(cur_test, 0, words_q.size());
  endtask

  task automatic test_ignored_sync();
    int base;
    cur_test = "test_ignored_sync";
    base = frames_done;
    s_axis_data_tready = 1'b1;
    pulse_vsync();
    wait_cycles(300);
    pulse_vsync();          // lands during fill
    wait_first_output();
    wait_cycles(300);
    pulse_vsync();          // lands during drain
    wait_frames(base + 1, 1'b0);
    check_frame(cur_test);
    wait_cycles(3000);      // nothing may follow
    check_count(cur_test, 0, words_q.size());
    check_count(cur_test, base + 1, frames_done);
  endtask

  task automatic test_two_frames();
    int base;
    cur_test = "test_two_frames";
    base = frames_done;
    s_axis_data_tready = 1'b1;
    pulse_vsync();
    wait_frames(base + 1, 1'b0);
    pulse_vsync();          // right after tlast
    check_frame(cur_test);
    wait_frames(base + 2, 1'b0);
    check_frame(cur_test);
    wait_cycles(8);
    check_count(cur_test, 0, words_q.size());
  endtask

  //--------------------------------------------------------------------------
  // ramp source, monitor, watchdog, sequence
  //--------------------------------------------------------------------------
  always @(posedge ad_clk) begin
    #2;
    ad_data_in = ad_data_in + 8'd1;  // one step per sample
  end

  // negedge sampling, everything driven at +2 ns has settled
  always @(negedge ad_clk) begin
    if (sys_rst_n) begin
      if (!s_axis_data_tready) begin
        check_flag(cur_test, 1'b0, ad_data_out_en);  // no handover without ready
      end
      if (ad_data_out_en) begin
        words_q.push_back(ad_data_out);
        lasts_q.push_back(s_axis_data_tlast);
        if (s_axis_data_tlast) begin
          frames_done++;
        end
      end
    end
  end

  initial begin
    #(watchdog_ns);
    report_failure("timeout: output frames never completed");
  end

  initial begin
    in_vsync           = 1'b0;
    s_axis_data_tready = 1'b0;
    wait (sys_rst_n === 1'b1);
    step();
    test_reset_idle();
    test_single_frame();
    test_backpressure();
    test_ignored_sync();
    test_two_frames();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic ad_clk,     // 50 MHz sample clock
  output logic sys_rst_n   // active low, released after 3 edges
);

  // 20 ns period
  initial begin
    ad_clk = 1'b0;
    forever #10 ad_clk = ~ad_clk;
  end

  initial begin
    sys_rst_n = 1'b0;
    repeat (3) @(posedge ad_clk);
    #2;
    sys_rst_n = 1'b1;  // off the edge, like the other stimulus
  end

endmodule

`default_nettype wire

/* vsync_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module vsync_sync (
  input  logic                                 ad_clk,
  input  logic                                 sys_rst_n,
  input  logic                                 in_vsync,     // async frame sync, active high
  input  logic [adc_fft_pkg::sample_width-1:0] ad_data_in,   // raw adc samples
  output logic                                 frame_start,  // one cycle per vsync rise
  output logic [adc_fft_pkg::sample_width-1:0] wr_data       // adc data, two stages late
);

  //--------------------------------------------------------------------------
  // frame sync resync chain
  //--------------------------------------------------------------------------
  logic vsync_t;   // first stage, may go metastable
  logic vsync_t0;  // settled copy
  logic vsync_t1;  // one cycle older, for edge detect

  // adc data pipeline
  logic [adc_fft_pkg::sample_width-1:0] ad_data_d0;
  logic [adc_fft_pkg::sample_width-1:0] ad_data_d1;

  always_ff @(posedge ad_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      vsync_t  <= 1'b0;
      vsync_t0 <= 1'b0;
      vsync_t1 <= 1'b0;
    end else begin
      vsync_t  <= in_vsync;
      vsync_t0 <= vsync_t;
      vsync_t1 <= vsync_t0;
    end
  end

  // rising edge on the two settled stages
  // high for exactly one cycle, the fsm decides whether it counts
  assign frame_start = vsync_t0 & ~vsync_t1;

  //--------------------------------------------------------------------------
  // sample delay
  //--------------------------------------------------------------------------
  // two stages so the sample written on the first wr_en cycle is
  // the one that arrived around the synchronized edge
  always_ff @(posedge ad_clk) begin
    ad_data_d0 <= ad_data_in;
    ad_data_d1 <= ad_data_d0;
  end

  assign wr_data = ad_data_d1;  // straight into the buffer write port

  // edge to first write
  //   vsync_t    E1
  //   vsync_t0   E2, frame_start high
  //   wr_en      E3
  //   first wr   E4, one more when the input edge misses E1 setup

endmodule

`default_nettype wire
